// File: bench/store_iq_patterns.txt
# D rob sq op imm uext rs1 rs1_valid rs2 rs2_valid (hex). F sq op imm rs1 rs2, ROB from LFSR.
# W preg, R rob, S entry, Q sq_full, K stall, I cycles; A sq entry lat, T sq lat (lat decimal).
K 0
D 01 0 2 123 0 05 1 06 1
A 0 0 3
T 0 3
S 0
# Data waits for rs2.
D 02 1 1 7f0 1 05 1 0a 0
A 1 0 3
I 3
W 0a
T 1 3
S 0
# Four stores ready at once, the youngest sits in slot 0.
D 03 2 2 010 0 11 0 11 0
D 04 3 0 020 0 10 0 10 0
D 05 4 1 030 1 10 0 10 0
D 06 5 2 040 0 10 0 10 0
W 11
A 2 0 3
T 2 3
S 0
D 07 6 0 050 0 10 0 10 0
W 10
A 3 1 3
T 3 3
A 4 2 4
T 4 4
A 5 3 5
T 5 5
A 6 0 6
T 6 6
S 1
S 2
S 3
S 0
# Store queue full.
Q 1
K 1
Q 0
K 0
# Redirect to ROB 09 keeps only ROB 08.
D 08 7 2 100 0 05 1 12 0
A 7 0 3
D 0a 8 1 110 0 13 0 13 0
D 09 9 0 120 0 13 0 13 0
R 09
W 12
T 7 3
W 13
I 6
S 0
# Redirect while the issue is in flight.
D 0b a 2 130 0 05 1 06 1
I 1
R 0b
I 6
# Fill the address bank.
F 8 2 200 05 06
F 9 1 204 05 06
F a 0 208 05 06
F b 2 20c 05 06
F c 1 210 05 06
F d 0 214 05 06
F e 2 218 05 06
F f 1 21c 05 06
A 8 0 -4
T 8 -4
A 9 1 -3
T 9 -3
A a 2 -2
T a -2
A b 3 -1
T b -1
A c 4 0
T c 0
A d 5 1
T d 1
A e 6 2
T e 2
A f 7 3
T f 3
K 1
S 3
K 0
D 1c 0 1 3ff 1 07 1 08 1
A 0 3 3
T 0 3
I 4

// File: bench/store_iq_tb.sv
`timescale 1ns/100ps
`default_nettype none

module store_iq_tb;
    import store_iq_pkg::*;

    localparam int WAIT_LIMIT = 40;  // Cycles that any single wait may take.

    logic                          clk;
    logic                          rst;
    logic                          dis_en;
    store_dispatch_t               dis;
    logic                          dis_stall;
    wakeup_t [INT_WAKEUP_PORT-1:0] wakeup;
    redirect_t                     redirect;
    logic                          success_en;
    logic [BANK_IDX_W-1:0]         success_idx;
    logic                          sq_full;
    addr_issue_t                   addr_issue;
    data_issue_t                   data_issue;

    store_dispatch_t stores [2**SQ_IDX_W];  // Last store dispatched with each sq_idx.
    addr_issue_t     addr_seen [$];
    data_issue_t     data_seen [$];
    int              addr_when [$];
    int              data_when [$];
    int              cyc = 0;
    int              mark;                  // Cycle of the last dispatch or wakeup.
    int              wake_port;             // Wakeups take turns over the ports.
    logic [15:0]     lfsr;

    store_issue_queue store_issue_queue_inst (
        .clk           (clk),
        .rst           (rst),
        .dis_en_i      (dis_en),
        .dis_i         (dis),
        .dis_stall_o   (dis_stall),
        .wakeup_i      (wakeup),
        .redirect_i    (redirect),
        .success_en_i  (success_en),
        .success_idx_i (success_idx),
        .sq_full_i     (sq_full),
        .addr_issue_o  (addr_issue),
        .data_issue_o  (data_issue)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Issue outputs come straight from flops, so they are settled here.
    always @(negedge clk) begin
        if (rst && addr_issue.valid) begin
            addr_seen.push_back(addr_issue);
            addr_when.push_back(cyc);
        end
        if (rst && data_issue.valid) begin
            data_seen.push_back(data_issue);
            data_when.push_back(cyc);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_addr_issue(input addr_issue_t got, input addr_issue_t want);
        if (got !== want) begin
            abort_run($sformatf("Fail addr_issue_o got %h exp %h", got, want));
        end
    endtask

    task automatic check_data_issue(input data_issue_t got, input data_issue_t want);
        if (got !== want) begin
            abort_run($sformatf("Fail data_issue_o got %h exp %h", got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("Fail %s got %h exp %h", name, got, want));
        end
    endtask

    task automatic check_latency(input string name, input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("Fail %s latency got %h exp %h", name, got, want));
        end
    endtask

    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            abort_run("A line of the pattern file has the wrong number of fields.");
        end
    endtask

    // Strobes last one cycle, so every step drops them first.
    task automatic next_cycle();
        @(negedge clk);
        dis_en     = 1'b0;
        wakeup     = '0;
        redirect   = '0;
        success_en = 1'b0;
    endtask

    // Fibonacci LFSR with taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_filler_rob(output rob_idx_t rob);
        rob = '0;
        for (int i = 0; i < ROB_IDX_W; i++) begin
            lfsr    = lfsr_next(lfsr);
            rob.idx = {rob.idx[ROB_IDX_W-2:0], lfsr[0]};
        end
    endtask

    function automatic store_size_t bytes_log2(input mem_op_t op);
        return (op == MEM_SW) ? 2'd2 : (op == MEM_SH) ? 2'd1 : 2'd0;
    endfunction

    task automatic dispatch_store(input store_dispatch_t d);
        int waited;
        waited = 0;
        next_cycle();
        while (dis_stall) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("Dispatch stayed stalled for too long.");
            end else begin
                next_cycle();
                waited++;
            end
        end
        dis              = d;
        dis_en           = 1'b1;
        stores[d.sq_idx] = d;
        mark             = cyc;
    endtask

    task automatic expect_addr_issue(input sq_idx_t sq, input logic [BANK_IDX_W-1:0] entry,
                                     input int lat);
        store_dispatch_t d;
        addr_issue_t     want;
        addr_issue_t     got;
        int              when;
        int              waited;
        waited = 0;
        while (addr_seen.size() == 0) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("No address issue arrived for sq_idx %0h.", sq));
            end else begin
                next_cycle();
                waited++;
            end
        end
        d            = stores[sq];
        want.valid   = 1'b1;
        want.idx     = entry;
        want.rs1     = d.rs1;
        want.rob_idx = d.rob_idx;
        want.sq_idx  = sq;
        want.imm     = d.imm;
        want.uext    = d.uext;
        want.size    = bytes_log2(d.mem_op);
        got          = addr_seen.pop_front();
        when         = addr_when.pop_front();
        check_addr_issue(got, want);
        check_latency("addr_issue_o", when - mark, lat);
    endtask

    task automatic expect_data_issue(input sq_idx_t sq, input int lat);
        store_dispatch_t d;
        data_issue_t     want;
        data_issue_t     got;
        int              when;
        int              waited;
        waited = 0;
        while (data_seen.size() == 0) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("No data issue arrived for sq_idx %0h.", sq));
            end else begin
                next_cycle();
                waited++;
            end
        end
        d            = stores[sq];
        want.valid   = 1'b1;
        want.rs2     = d.rs2;
        want.sq_idx  = sq;
        want.size    = bytes_log2(d.mem_op);
        want.rob_idx = d.rob_idx;
        got          = data_seen.pop_front();
        when         = data_when.pop_front();
        check_data_issue(got, want);
        check_latency("data_issue_o", when - mark, lat);
    endtask

    initial begin
        logic [8*8-1:0]   cmd;
        logic [8*128-1:0] line;
        int               fd;
        int               code;
        int               v [9];
        store_dispatch_t  d;
        rob_idx_t         rob;

        rst         = 1'b0;
        dis_en      = 1'b0;
        dis         = '0;
        wakeup      = '0;
        redirect    = '0;
        success_en  = 1'b0;
        success_idx = '0;
        sq_full     = 1'b0;
        lfsr        = 16'd32;
        mark        = 0;
        wake_port   = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_flag("addr_issue_o.valid", addr_issue.valid, 1'b0);
        check_flag("data_issue_o.valid", data_issue.valid, 1'b0);
        check_flag("dis_stall_o", dis_stall, 1'b0);

        fd = $fopen("bench/store_iq_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open bench/store_iq_patterns.txt.");
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "D") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                               v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                check_fields(code, 9);
                d.rob_idx   = v[0][5:0];
                d.sq_idx    = v[1][3:0];
                d.mem_op    = mem_op_t'(v[2][1:0]);
                d.imm       = v[3][11:0];
                d.uext      = v[4][0];
                d.rs1       = v[5][5:0];
                d.rs1_valid = v[6][0];
                d.rs2       = v[7][5:0];
                d.rs2_valid = v[8][0];
                dispatch_store(d);
            end else if (cmd == "F") begin
                code = $fscanf(fd, "%h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]);
                check_fields(code, 5);
                next_filler_rob(rob);  // Filler stores take a random ROB index.
                d.rob_idx   = rob;
                d.sq_idx    = v[0][3:0];
                d.mem_op    = mem_op_t'(v[1][1:0]);
                d.imm       = v[2][11:0];
                d.uext      = 1'b0;
                d.rs1       = v[3][5:0];
                d.rs1_valid = 1'b1;
                d.rs2       = v[4][5:0];
                d.rs2_valid = 1'b1;
                dispatch_store(d);
            end else if (cmd == "A") begin
                code = $fscanf(fd, "%h %h %d", v[0], v[1], v[2]);
                check_fields(code, 3);
                expect_addr_issue(v[0][3:0], v[1][2:0], v[2]);
            end else if (cmd == "T") begin
                code = $fscanf(fd, "%h %d", v[0], v[1]);
                check_fields(code, 2);
                expect_data_issue(v[0][3:0], v[1]);
            end else begin
                code = $fscanf(fd, "%h", v[0]);
                check_fields(code, 1);
                if (cmd == "I") begin
                    repeat (v[0]) next_cycle();
                end else if (cmd == "K") begin
                    next_cycle();
                    check_flag("dis_stall_o", dis_stall, v[0][0]);
                end else begin
                    next_cycle();
                    if (cmd == "W") begin
                        wakeup[wake_port].en = 1'b1;
                        wakeup[wake_port].rd = v[0][5:0];
                        wake_port            = (wake_port + 1) % INT_WAKEUP_PORT;
                        mark                 = cyc;
                    end else if (cmd == "R") begin
                        redirect.en      = 1'b1;
                        redirect.rob_idx = v[0][5:0];
                    end else if (cmd == "S") begin
                        success_en  = 1'b1;
                        success_idx = v[0][2:0];
                    end else if (cmd == "Q") begin
                        sq_full = v[0][0];
                    end else begin
                        abort_run("Unknown command in the pattern file.");
                    end
                end
            end
        end
        $fclose(fd);

        if (addr_seen.size() != 0 || data_seen.size() != 0) begin
            abort_run("An issue appeared that no pattern line expected.");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: hw/store_addr_bank.sv
`timescale 1ns/100ps
`default_nettype none

module store_addr_bank (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    alloc_i,
    input  store_iq_pkg::addr_entry_t               alloc_i_entry,
    input  store_iq_pkg::preg_t                     rs1_i,
    input  logic                                    rs1_valid_i,
    input  store_iq_pkg::wakeup_t [store_iq_pkg::INT_WAKEUP_PORT-1:0] wakeup_i,
    input  store_iq_pkg::redirect_t                 redirect_i,
    input  logic                                    success_en_i,
    input  logic [store_iq_pkg::BANK_IDX_W-1:0]     success_idx_i,
    output logic                                    full_o,
    output logic                                    sel_o,
    output store_iq_pkg::addr_issue_t               sel_payload_o
);
    import store_iq_pkg::*;

    logic [BANK_SIZE-1:0]  valid_q, issued_q, rdy_q;
    logic [BANK_SIZE-1:0]  older_q [BANK_SIZE];  // Row i, bit j: entry i is older than j.
    addr_entry_t           entry_q [BANK_SIZE];
    preg_t                 rs1_q   [BANK_SIZE];
    logic [BANK_SIZE-1:0]  alloc_dec, success_dec, ready, sel_vec, keep;
    logic [BANK_IDX_W-1:0] free_idx, sel_idx;
    addr_issue_t           sel_pay, pay_q;
    logic                  sel_q;

    // Lowest free slot.
    always_comb begin
        free_idx = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = BANK_IDX_W'(i);
            end
        end
    end

    // A store dispatched under a redirect is younger, so it is dropped.
    assign alloc_dec   = (alloc_i & ~redirect_i.en) ? (BANK_SIZE'(1) << free_idx) : '0;
    assign success_dec = success_en_i ? (BANK_SIZE'(1) << success_idx_i) : '0;
    assign ready       = valid_q & ~issued_q & rdy_q;

    // Oldest ready entry wins.
    always_comb begin
        for (int i = 0; i < BANK_SIZE; i++) begin
            sel_vec[i] = ready[i] & ~redirect_i.en;
            for (int j = 0; j < BANK_SIZE; j++) begin
                if (ready[j] && older_q[j][i]) begin
                    sel_vec[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            if (sel_vec[i]) begin
                sel_idx = BANK_IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BANK_SIZE; i++) begin
            keep[i] = ~redirect_i.en | is_older(entry_q[i].rob_idx, redirect_i.rob_idx);
        end
    end

    always_comb begin
        sel_pay.valid   = |sel_vec;
        sel_pay.idx     = sel_idx;
        sel_pay.rs1     = rs1_q[sel_idx];
        sel_pay.rob_idx = entry_q[sel_idx].rob_idx;
        sel_pay.sq_idx  = entry_q[sel_idx].sq_idx;
        sel_pay.imm     = entry_q[sel_idx].imm;
        sel_pay.uext    = entry_q[sel_idx].uext;
        sel_pay.size    = entry_q[sel_idx].size;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q  <= '0;
            issued_q <= '0;
            rdy_q    <= '0;
            sel_q    <= 1'b0;
            for (int i = 0; i < BANK_SIZE; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            valid_q  <= ((valid_q & keep) | alloc_dec) & ~success_dec;
            issued_q <= (issued_q | sel_vec) & ~alloc_dec;  // Stays held until success.
            sel_q    <= |sel_vec;
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (alloc_dec[i]) begin
                    rdy_q[i] <= rs1_valid_i | wakeup_hit(wakeup_i, rs1_i);
                end else begin
                    rdy_q[i] <= rdy_q[i] | wakeup_hit(wakeup_i, rs1_q[i]);
                end
            end
            // New entry is younger than everything present.
            if (|alloc_dec) begin
                for (int i = 0; i < BANK_SIZE; i++) begin
                    older_q[i][free_idx] <= 1'b1;
                end
                older_q[free_idx] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|alloc_dec) begin
            entry_q[free_idx] <= alloc_i_entry;
            rs1_q[free_idx]   <= rs1_i;
        end
        pay_q <= sel_pay;
    end

    assign full_o        = &valid_q;
    assign sel_o         = sel_q;
    assign sel_payload_o = pay_q;

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(sel_vec))
        else $error("Address select is not one-hot.");

    a_success_legal: assert property (@(posedge clk) disable iff (!rst)
        success_en_i |-> valid_q[success_idx_i] && issued_q[success_idx_i])
        else $error("Success names an entry that was not issued.");

endmodule

`default_nettype wire

// File: hw/store_data_bank.sv
`timescale 1ns/100ps
`default_nettype none

module store_data_bank (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    alloc_i,
    input  store_iq_pkg::data_entry_t               alloc_i_entry,
    input  store_iq_pkg::preg_t                     rs2_i,
    input  logic                                    rs2_valid_i,
    input  store_iq_pkg::wakeup_t [store_iq_pkg::INT_WAKEUP_PORT-1:0] wakeup_i,
    input  store_iq_pkg::redirect_t                 redirect_i,
    output logic                                    full_o,
    output logic                                    sel_o,
    output store_iq_pkg::data_issue_t               sel_payload_o
);
    import store_iq_pkg::*;

    logic [BANK_SIZE-1:0]  valid_q, rdy_q;
    logic [BANK_SIZE-1:0]  older_q [BANK_SIZE];  // Row i, bit j: entry i is older than j.
    data_entry_t           entry_q [BANK_SIZE];
    preg_t                 rs2_q   [BANK_SIZE];
    logic [BANK_SIZE-1:0]  alloc_dec, ready, sel_vec, keep;
    logic [BANK_IDX_W-1:0] free_idx, sel_idx;
    data_issue_t           sel_pay, pay_q;
    logic                  sel_q;

    always_comb begin
        free_idx = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = BANK_IDX_W'(i);
            end
        end
    end

    assign alloc_dec = (alloc_i & ~redirect_i.en) ? (BANK_SIZE'(1) << free_idx) : '0;
    assign ready     = valid_q & rdy_q;

    always_comb begin
        for (int i = 0; i < BANK_SIZE; i++) begin
            sel_vec[i] = ready[i] & ~redirect_i.en;
            for (int j = 0; j < BANK_SIZE; j++) begin
                if (ready[j] && older_q[j][i]) begin
                    sel_vec[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            if (sel_vec[i]) begin
                sel_idx = BANK_IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BANK_SIZE; i++) begin
            keep[i] = ~redirect_i.en | is_older(entry_q[i].rob_idx, redirect_i.rob_idx);
        end
    end

    always_comb begin
        sel_pay.valid   = |sel_vec;
        sel_pay.rs2     = rs2_q[sel_idx];
        sel_pay.sq_idx  = entry_q[sel_idx].sq_idx;
        sel_pay.size    = entry_q[sel_idx].size;
        sel_pay.rob_idx = entry_q[sel_idx].rob_idx;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            rdy_q   <= '0;
            sel_q   <= 1'b0;
            for (int i = 0; i < BANK_SIZE; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            // Data entries leave as soon as they are picked.
            valid_q <= ((valid_q & keep) | alloc_dec) & ~sel_vec;
            sel_q   <= |sel_vec;
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (alloc_dec[i]) begin
                    rdy_q[i] <= rs2_valid_i | wakeup_hit(wakeup_i, rs2_i);
                end else begin
                    rdy_q[i] <= rdy_q[i] | wakeup_hit(wakeup_i, rs2_q[i]);
                end
            end
            if (|alloc_dec) begin
                for (int i = 0; i < BANK_SIZE; i++) begin
                    older_q[i][free_idx] <= 1'b1;
                end
                older_q[free_idx] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|alloc_dec) begin
            entry_q[free_idx] <= alloc_i_entry;
            rs2_q[free_idx]   <= rs2_i;
        end
        pay_q <= sel_pay;
    end

    assign full_o        = &valid_q;
    assign sel_o         = sel_q;
    assign sel_payload_o = pay_q;

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(sel_vec))
        else $error("Data select is not one-hot.");

endmodule

`default_nettype wire

// File: hw/store_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module store_dispatch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dis_en_i,
    input  store_iq_pkg::store_dispatch_t dis_i,
    input  logic                          addr_full_i,
    input  logic                          data_full_i,
    input  logic                          sq_full_i,
    output logic                          alloc_o,
    output store_iq_pkg::addr_entry_t     addr_alloc_o,
    output store_iq_pkg::data_entry_t     data_alloc_o,
    output store_iq_pkg::preg_t           rs1_o,
    output store_iq_pkg::preg_t           rs2_o,
    output logic                          rs1_valid_o,
    output logic                          rs2_valid_o,
    output logic                          dis_stall_o
);
    import store_iq_pkg::*;

    store_size_t size;

    always_comb begin
        case (dis_i.mem_op)
            MEM_SW:  size = 2'd2;
            MEM_SH:  size = 2'd1;
            default: size = 2'd0;  // Byte store.
        endcase
    end

    assign dis_stall_o = addr_full_i | data_full_i | sq_full_i;
    assign alloc_o     = dis_en_i & ~dis_stall_o;

    // Same store goes into both banks.
    assign addr_alloc_o = '{rob_idx: dis_i.rob_idx, sq_idx: dis_i.sq_idx, imm: dis_i.imm,
                            uext: dis_i.uext, size: size};
    assign data_alloc_o = '{rob_idx: dis_i.rob_idx, sq_idx: dis_i.sq_idx, size: size};

    assign rs1_o       = dis_i.rs1;
    assign rs1_valid_o = dis_i.rs1_valid;
    assign rs2_o       = dis_i.rs2;
    assign rs2_valid_o = dis_i.rs2_valid;

    a_no_dis_when_stalled: assert property (@(posedge clk) disable iff (!rst)
        dis_en_i |-> !dis_stall_o)
        else $error("Dispatch arrived while stalled.");

endmodule

`default_nettype wire

// File: hw/store_iq_pkg.sv
`default_nettype none

package store_iq_pkg;

    localparam int BANK_SIZE       = 8;
    localparam int BANK_IDX_W      = 3;
    localparam int INT_WAKEUP_PORT = 2;
    localparam int ROB_IDX_W       = 5;
    localparam int PREG_W          = 6;
    localparam int SQ_IDX_W        = 4;
    localparam int IMM_W           = 12;

    // Direction bit flips each time the ROB index wraps.
    typedef struct packed {
        logic                 dir;
        logic [ROB_IDX_W-1:0] idx;
    } rob_idx_t;

    typedef logic [PREG_W-1:0]   preg_t;
    typedef logic [SQ_IDX_W-1:0] sq_idx_t;
    typedef logic [1:0]          store_size_t;  // Log2 of the byte count.

    typedef enum logic [1:0] {
        MEM_SB = 2'd0,
        MEM_SH = 2'd1,
        MEM_SW = 2'd2
    } mem_op_t;

    typedef struct packed {
        rob_idx_t         rob_idx;
        sq_idx_t          sq_idx;
        mem_op_t          mem_op;
        logic [IMM_W-1:0] imm;
        logic             uext;
        preg_t            rs1;
        logic             rs1_valid;
        preg_t            rs2;
        logic             rs2_valid;
    } store_dispatch_t;

    typedef struct packed {
        rob_idx_t         rob_idx;
        sq_idx_t          sq_idx;
        logic [IMM_W-1:0] imm;
        logic             uext;
        store_size_t      size;
    } addr_entry_t;

    typedef struct packed {
        rob_idx_t    rob_idx;
        sq_idx_t     sq_idx;
        store_size_t size;
    } data_entry_t;

    typedef struct packed {
        logic  en;
        preg_t rd;
    } wakeup_t;

    typedef struct packed {
        logic     en;
        rob_idx_t rob_idx;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [BANK_IDX_W-1:0] idx;    // Entry to name in the success report.
        preg_t                 rs1;
        rob_idx_t              rob_idx;
        sq_idx_t               sq_idx;
        logic [IMM_W-1:0]      imm;
        logic                  uext;
        store_size_t           size;
    } addr_issue_t;

    typedef struct packed {
        logic        valid;
        preg_t       rs2;
        sq_idx_t     sq_idx;
        store_size_t size;
        rob_idx_t    rob_idx;
    } data_issue_t;

    // Wrap-aware age compare, true when a is older than b.
    function automatic logic is_older(input rob_idx_t a, input rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

    function automatic logic wakeup_hit(input wakeup_t [INT_WAKEUP_PORT-1:0] wk,
                                        input preg_t p);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < INT_WAKEUP_PORT; i++) begin
            hit |= wk[i].en & (wk[i].rd == p);
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

// File: hw/store_issue_out.sv
`timescale 1ns/100ps
`default_nettype none

module store_issue_out (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      addr_sel_i,
    input  store_iq_pkg::addr_issue_t addr_payload_i,
    input  logic                      data_sel_i,
    input  store_iq_pkg::data_issue_t data_payload_i,
    input  store_iq_pkg::redirect_t   redirect_i,
    output store_iq_pkg::addr_issue_t addr_issue_o,
    output store_iq_pkg::data_issue_t data_issue_o
);
    import store_iq_pkg::*;

    logic        addr_kill, data_kill;
    logic        addr_vld_q, data_vld_q;
    addr_issue_t addr_q;
    data_issue_t data_q;

    // Anything not older than the redirect point is squashed here.
    assign addr_kill = redirect_i.en & ~is_older(addr_payload_i.rob_idx, redirect_i.rob_idx);
    assign data_kill = redirect_i.en & ~is_older(data_payload_i.rob_idx, redirect_i.rob_idx);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            addr_vld_q <= 1'b0;
            data_vld_q <= 1'b0;
        end else begin
            addr_vld_q <= addr_sel_i & ~addr_kill;
            data_vld_q <= data_sel_i & ~data_kill;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr_payload_i;
        data_q <= data_payload_i;
    end

    always_comb begin
        addr_issue_o       = addr_q;
        addr_issue_o.valid = addr_vld_q;
        data_issue_o       = data_q;
        data_issue_o.valid = data_vld_q;
    end

endmodule

`default_nettype wire

// File: hw/store_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module store_issue_queue (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    dis_en_i,
    input  store_iq_pkg::store_dispatch_t           dis_i,
    output logic                                    dis_stall_o,
    input  store_iq_pkg::wakeup_t [store_iq_pkg::INT_WAKEUP_PORT-1:0] wakeup_i,
    input  store_iq_pkg::redirect_t                 redirect_i,
    input  logic                                    success_en_i,
    input  logic [store_iq_pkg::BANK_IDX_W-1:0]     success_idx_i,
    input  logic                                    sq_full_i,
    output store_iq_pkg::addr_issue_t               addr_issue_o,
    output store_iq_pkg::data_issue_t               data_issue_o
);
    import store_iq_pkg::*;

    logic        alloc, rs1_valid, rs2_valid, addr_full, data_full;
    addr_entry_t addr_alloc;
    data_entry_t data_alloc;
    preg_t       rs1, rs2;
    logic        addr_sel, data_sel;
    addr_issue_t addr_payload;
    data_issue_t data_payload;

    store_dispatch store_dispatch_inst (
        .clk          (clk),
        .rst          (rst),
        .dis_en_i     (dis_en_i),
        .dis_i        (dis_i),
        .addr_full_i  (addr_full),
        .data_full_i  (data_full),
        .sq_full_i    (sq_full_i),
        .alloc_o      (alloc),
        .addr_alloc_o (addr_alloc),
        .data_alloc_o (data_alloc),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rs1_valid_o  (rs1_valid),
        .rs2_valid_o  (rs2_valid),
        .dis_stall_o  (dis_stall_o)
    );

    store_addr_bank store_addr_bank_inst (
        .clk           (clk),
        .rst           (rst),
        .alloc_i       (alloc),
        .alloc_i_entry (addr_alloc),
        .rs1_i         (rs1),
        .rs1_valid_i   (rs1_valid),
        .wakeup_i      (wakeup_i),
        .redirect_i    (redirect_i),
        .success_en_i  (success_en_i),
        .success_idx_i (success_idx_i),
        .full_o        (addr_full),
        .sel_o         (addr_sel),
        .sel_payload_o (addr_payload)
    );

    store_data_bank store_data_bank_inst (
        .clk           (clk),
        .rst           (rst),
        .alloc_i       (alloc),
        .alloc_i_entry (data_alloc),
        .rs2_i         (rs2),
        .rs2_valid_i   (rs2_valid),
        .wakeup_i      (wakeup_i),
        .redirect_i    (redirect_i),
        .full_o        (data_full),
        .sel_o         (data_sel),
        .sel_payload_o (data_payload)
    );

    store_issue_out store_issue_out_inst (
        .clk            (clk),
        .rst            (rst),
        .addr_sel_i     (addr_sel),
        .addr_payload_i (addr_payload),
        .data_sel_i     (data_sel),
        .data_payload_i (data_payload),
        .redirect_i     (redirect_i),
        .addr_issue_o   (addr_issue_o),
        .data_issue_o   (data_issue_o)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the store issue queue testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f store_iq.f --top-module store_iq_tb -o store_iq_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

out=$(./obj_dir/store_iq_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$out" | grep -q -F '** PASS **'; then
    exit 0
fi
echo "Pass message not found in the simulation output."
exit 1

// File: store_iq.f
hw/store_iq_pkg.sv
hw/store_dispatch.sv
hw/store_addr_bank.sv
hw/store_data_bank.sv
hw/store_issue_out.sv
hw/store_issue_queue.sv
bench/store_iq_tb.sv
